// File: src/aq32_consts.svh
`ifndef AQ32_CONSTS_SVH
`define AQ32_CONSTS_SVH

////////////////////////////////////////
// Timing
////////////////////////////////////////

// Clocks per 1 ms tick at 25.175 MHz
`define AQ32_TICK_DIV 25175

// Keyboard FIFO entries as a power of two
`define AQ32_KBBUF_DEPTH 16

////////////////////////////////////////
// Address map
////////////////////////////////////////

`define AQ32_ADDR_KEYBUF 32'h0000_2010
// Eight words
`define AQ32_ADDR_VIDEO 32'h0000_2040
// Four words
`define AQ32_ADDR_TIMER 32'h0000_2080

// Audio clamp limits
`define AQ32_SAMPLE_MAX 16'h7FFF
`define AQ32_SAMPLE_MIN 16'h8000

`endif

// File: src/aq32_bus_pkg.sv
`default_nettype none

package aq32_bus_pkg;

    // Master side of a Wishbone classic cycle
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

    // One accept pulse per peripheral
    typedef struct packed {
        logic keybuf;
        logic video;
        logic timer;
    } periph_sel_t;

endpackage

`default_nettype wire

// File: src/aq32_periph_pkg.sv
`default_nettype none

package aq32_periph_pkg;

    // Flags ordered as vctrl bits 7..0
    typedef struct packed {
        logic       bm_wrap;
        logic       layer2_enable;
        logic       sprites_enable;
        logic       gfx_tilemode;
        logic       gfx_enable;
        logic       text_priority;
        logic       text_mode80;
        logic       text_enable;
        logic [8:0] l1_scrx;
        logic [7:0] l1_scry;
        logic [8:0] l2_scrx;
        logic [7:0] l2_scry;
        logic [8:0] irqline;
    } video_cfg_t;

    typedef struct packed {
        logic signed [15:0] left;
        logic signed [15:0] right;
    } stereo_t;

    typedef struct packed {
        logic        valid;
        logic [15:0] data;
    } key_entry_t;

    typedef struct packed {
        logic timer;
        logic keybuf;
    } irq_t;

endpackage

`default_nettype wire

// File: src/bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "aq32_consts.svh"

module bus_decode (
    input  logic                      clk,
    input  logic                      reset,
    input  aq32_bus_pkg::wb_req_t     wb_req,
    output aq32_bus_pkg::wb_rsp_t     wb_rsp,
    output aq32_bus_pkg::periph_sel_t sel,
    input  logic [31:0]               keybuf_rdata,
    input  logic [31:0]               video_rdata,
    input  logic [31:0]               timer_rdata
);
    import aq32_bus_pkg::*;

    wb_rsp_t     rsp_q;
    logic        accept;
    logic        hit_keybuf;
    logic        hit_video;
    logic        hit_timer;
    logic [31:0] rdata_mux;

    // No new acceptance while ack is out, so every cycle gets one ack
    assign accept = wb_req.cyc && wb_req.stb && !rsp_q.ack;

    // Block compares with low bits masked by block size
    assign hit_keybuf = {wb_req.adr[31:2], 2'b0} == `AQ32_ADDR_KEYBUF;
    assign hit_video  = {wb_req.adr[31:5], 5'b0} == `AQ32_ADDR_VIDEO;
    assign hit_timer  = {wb_req.adr[31:4], 4'b0} == `AQ32_ADDR_TIMER;

    assign sel.keybuf = accept && hit_keybuf;
    assign sel.video  = accept && hit_video;
    assign sel.timer  = accept && hit_timer;

    always_comb begin
        rdata_mux = '0;
        if (hit_keybuf) begin
            rdata_mux = keybuf_rdata;
        end else if (hit_video) begin
            rdata_mux = video_rdata;
        end else if (hit_timer) begin
            rdata_mux = timer_rdata;
        end
    end

    ////////////////////////////////////////
    // Acknowledge and read data
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rsp_q <= '0;
        end else begin
            rsp_q.ack <= accept;
            // Unmapped addresses fall through to zero
            if (accept) begin
                rsp_q.dat_r <= rdata_mux;
            end
        end
    end

    assign wb_rsp = rsp_q;

endmodule

`default_nettype wire

// File: src/mtime_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "aq32_consts.svh"

module mtime_timer #(
    parameter int unsigned TICK_DIV = `AQ32_TICK_DIV
) (
    input  logic                  clk,
    input  logic                  reset,
    input  aq32_bus_pkg::wb_req_t wb_req,
    input  logic                  sel_timer,
    output logic [31:0]           rdata,
    output logic                  irq_timer
);
    localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [CNT_W-1:0] tick_cnt_q;
    logic             tick_q;
    logic [63:0]      mtime_q;
    logic [63:0]      mtimecmp_q;
    logic             irq_q;
    logic             wr;

    assign wr = sel_timer && wb_req.we;

    // 1 ms tick pulse one cycle after the wrap
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_cnt_q <= '0;
            tick_q     <= 1'b0;
        end else begin
            tick_q <= 1'b0;
            if (tick_cnt_q == CNT_W'(TICK_DIV - 1)) begin
                tick_cnt_q <= '0;
                tick_q     <= 1'b1;
            end else begin
                tick_cnt_q <= tick_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mtime_q    <= '0;
            mtimecmp_q <= '0;
            irq_q      <= 1'b0;
        end else begin
            // Bus write wins over the tick
            if (wr && !wb_req.adr[3]) begin
                if (wb_req.adr[2]) mtime_q[63:32] <= wb_req.dat_w;
                else               mtime_q[31:0]  <= wb_req.dat_w;
            end else if (tick_q) begin
                mtime_q <= mtime_q + 64'd1;
            end

            if (wr && wb_req.adr[3]) begin
                if (wb_req.adr[2]) mtimecmp_q[63:32] <= wb_req.dat_w;
                else               mtimecmp_q[31:0]  <= wb_req.dat_w;
            end

            irq_q <= (mtimecmp_q <= mtime_q);
        end
    end

    always_comb begin
        case (wb_req.adr[3:2])
            2'd0:    rdata = mtime_q[31:0];
            2'd1:    rdata = mtime_q[63:32];
            2'd2:    rdata = mtimecmp_q[31:0];
            default: rdata = mtimecmp_q[63:32];
        endcase
    end

    assign irq_timer = irq_q;

endmodule

`default_nettype wire

// File: src/key_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "aq32_consts.svh"

module key_buffer (
    input  logic                        clk,
    input  logic                        reset,
    input  aq32_periph_pkg::key_entry_t key_in,
    input  aq32_bus_pkg::wb_req_t       wb_req,
    input  logic                        sel_keybuf,
    output logic [31:0]                 rdata,
    output logic                        not_empty
);
    localparam int DEPTH = `AQ32_KBBUF_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    logic [15:0]    mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic           empty;
    logic           full;
    logic           push;
    logic           pop;
    logic           clear;

    assign empty = (count_q == '0);
    assign full  = (count_q == (PTR_W+1)'(DEPTH));

    // Keys arriving while full are lost
    assign push  = key_in.valid && !full;
    assign pop   = sel_keybuf && !wb_req.we && !empty;
    assign clear = sel_keybuf && wb_req.we;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= key_in.data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (clear) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            if (push && !pop)      count_q <= count_q + 1'b1;
            else if (pop && !push) count_q <= count_q - 1'b1;
        end
    end

    // Empty flag on top and head entry below
    assign rdata     = {empty, 15'b0, empty ? 16'h0000 : mem[rd_ptr_q]};
    assign not_empty = !empty;

endmodule

`default_nettype wire

// File: src/video_regs.sv
`timescale 1ns/1ps
`default_nettype none

module video_regs (
    input  logic                        clk,
    input  logic                        reset,
    input  aq32_bus_pkg::wb_req_t       wb_req,
    input  logic                        sel_video,
    output logic [31:0]                 rdata,
    output aq32_periph_pkg::video_cfg_t cfg
);
    import aq32_periph_pkg::*;

    video_cfg_t cfg_q;
    logic [7:0] vctrl;

    assign vctrl = {cfg_q.bm_wrap, cfg_q.layer2_enable, cfg_q.sprites_enable,
                    cfg_q.gfx_tilemode, cfg_q.gfx_enable, cfg_q.text_priority,
                    cfg_q.text_mode80, cfg_q.text_enable};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_q <= '0;
        end else if (sel_video && wb_req.we) begin
            case (wb_req.adr[4:2])
                3'd0: {cfg_q.bm_wrap, cfg_q.layer2_enable, cfg_q.sprites_enable,
                       cfg_q.gfx_tilemode, cfg_q.gfx_enable, cfg_q.text_priority,
                       cfg_q.text_mode80, cfg_q.text_enable} <= wb_req.dat_w[7:0];
                3'd3: cfg_q.irqline <= wb_req.dat_w[8:0];
                3'd4: cfg_q.l1_scrx <= wb_req.dat_w[8:0];
                3'd5: cfg_q.l1_scry <= wb_req.dat_w[7:0];
                3'd6: cfg_q.l2_scrx <= wb_req.dat_w[8:0];
                3'd7: cfg_q.l2_scry <= wb_req.dat_w[7:0];
                default: ;
            endcase
        end
    end

    // Words 1 and 2 read as zero
    always_comb begin
        case (wb_req.adr[4:2])
            3'd0:    rdata = {24'b0, vctrl};
            3'd3:    rdata = {23'b0, cfg_q.irqline};
            3'd4:    rdata = {23'b0, cfg_q.l1_scrx};
            3'd5:    rdata = {24'b0, cfg_q.l1_scry};
            3'd6:    rdata = {23'b0, cfg_q.l2_scrx};
            3'd7:    rdata = {24'b0, cfg_q.l2_scry};
            default: rdata = '0;
        endcase
    end

    assign cfg = cfg_q;

endmodule

`default_nettype wire

// File: src/audio_mixer.sv
`timescale 1ns/1ps
`default_nettype none

`include "aq32_consts.svh"

module audio_mixer (
    input  logic                     clk,
    input  logic                     reset,
    input  aq32_periph_pkg::stereo_t a,
    input  aq32_periph_pkg::stereo_t b,
    output aq32_periph_pkg::stereo_t mix
);
    import aq32_periph_pkg::*;

    stereo_t     mix_q;
    logic [16:0] sum_l;
    logic [16:0] sum_r;

    // Top two bits disagree on overflow
    function automatic logic [15:0] clamp(input logic [16:0] sum);
        logic [15:0] result;
        result = sum[15:0];
        if (sum[16:15] == 2'b01)      result = `AQ32_SAMPLE_MAX;
        else if (sum[16:15] == 2'b10) result = `AQ32_SAMPLE_MIN;
        return result;
    endfunction

    assign sum_l = {a.left[15], a.left} + {b.left[15], b.left};
    assign sum_r = {a.right[15], a.right} + {b.right[15], b.right};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mix_q <= '0;
        end else begin
            mix_q.left  <= clamp(sum_l);
            mix_q.right <= clamp(sum_r);
        end
    end

    assign mix = mix_q;

endmodule

`default_nettype wire

// File: src/aq32_periph_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "aq32_consts.svh"

module aq32_periph_top #(
    parameter int unsigned TICK_DIV = `AQ32_TICK_DIV
) (
    input  logic                         clk,
    input  logic                         reset,
    input  aq32_bus_pkg::wb_req_t        wb_req,
    output aq32_bus_pkg::wb_rsp_t        wb_rsp,
    input  aq32_periph_pkg::key_entry_t  key_in,
    input  aq32_periph_pkg::stereo_t     pcm_in,
    input  aq32_periph_pkg::stereo_t     fm_in,
    output aq32_periph_pkg::stereo_t     audio_out,
    output aq32_periph_pkg::video_cfg_t  video_cfg,
    output aq32_periph_pkg::irq_t        irq
);
    import aq32_bus_pkg::*;

    periph_sel_t sel;
    logic [31:0] keybuf_rdata;
    logic [31:0] video_rdata;
    logic [31:0] timer_rdata;
    logic        irq_timer;
    logic        irq_keybuf;

    assign irq = '{timer: irq_timer, keybuf: irq_keybuf};

    ////////////////////////////////////////
    // Bus side
    ////////////////////////////////////////
    bus_decode u_bus_decode (
        .clk          (clk),
        .reset        (reset),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .sel          (sel),
        .keybuf_rdata (keybuf_rdata),
        .video_rdata  (video_rdata),
        .timer_rdata  (timer_rdata)
    );

    ////////////////////////////////////////
    // Peripherals
    ////////////////////////////////////////
    mtime_timer #(
        .TICK_DIV (TICK_DIV)
    ) u_mtime_timer (
        .clk       (clk),
        .reset     (reset),
        .wb_req    (wb_req),
        .sel_timer (sel.timer),
        .rdata     (timer_rdata),
        .irq_timer (irq_timer)
    );

    key_buffer u_key_buffer (
        .clk        (clk),
        .reset      (reset),
        .key_in     (key_in),
        .wb_req     (wb_req),
        .sel_keybuf (sel.keybuf),
        .rdata      (keybuf_rdata),
        .not_empty  (irq_keybuf)
    );

    video_regs u_video_regs (
        .clk       (clk),
        .reset     (reset),
        .wb_req    (wb_req),
        .sel_video (sel.video),
        .rdata     (video_rdata),
        .cfg       (video_cfg)
    );

    audio_mixer u_audio_mixer (
        .clk   (clk),
        .reset (reset),
        .a     (pcm_in),
        .b     (fm_in),
        .mix   (audio_out)
    );

endmodule

`default_nettype wire

// File: dv/tb_aq32_periph.sv
`timescale 1ns/1ps
`default_nettype none

`include "aq32_consts.svh"

module tb_aq32_periph;
    import aq32_bus_pkg::*;
    import aq32_periph_pkg::*;

    localparam string TRACE_FILE  = "dv/aq32_periph_trace.txt";
    localparam int    ACK_WAIT    = 4;
    localparam int    LINE_CYCLES = 50;

    logic       clk;
    logic       reset;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    key_entry_t key_in;
    stereo_t    pcm_in;
    stereo_t    fm_in;
    stereo_t    audio_out;
    video_cfg_t video_cfg;
    irq_t       irq;

    // Expected video register contents
    video_cfg_t exp_cfg;
    string      lines[$];
    int         limit_cycles;
    int         test_errors;
    int         total_errors;
    int         tests_passed;
    int         tests_failed;

    aq32_periph_top #(
        .TICK_DIV (8)
    ) DUT (
        .clk       (clk),
        .reset     (reset),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .key_in    (key_in),
        .pcm_in    (pcm_in),
        .fm_in     (fm_in),
        .audio_out (audio_out),
        .video_cfg (video_cfg),
        .irq       (irq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    task automatic note_error();
        test_errors++;
        total_errors++;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    // One Wishbone classic cycle after a random gap
    task automatic bus_cycle(input logic we, input logic [31:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int   waited;
        logic acked;
        idle($urandom % 4);
        @(negedge clk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, sel: 4'hf, adr: adr, dat_w: wdata};
        acked  = 1'b0;
        waited = 0;
        rdata  = '0;
        while (!acked && waited < ACK_WAIT) begin
            @(negedge clk);
            waited++;
            if (wb_rsp.ack) begin
                acked = 1'b1;
                rdata = wb_rsp.dat_r;
            end
        end
        wb_req = '0;
        if (!acked) begin
            $display("No acknowledge within %0d cycles for the access to %h", ACK_WAIT, adr);
            note_error();
        end
    endtask

    // Field widths of the video register map
    function automatic video_cfg_t video_after_write(input video_cfg_t cfg,
                                                     input logic [31:0] adr,
                                                     input logic [31:0] data);
        video_cfg_t next;
        next = cfg;
        case (adr[4:2])
            3'd0: begin
                next.text_enable    = data[0];
                next.text_mode80    = data[1];
                next.text_priority  = data[2];
                next.gfx_enable     = data[3];
                next.gfx_tilemode   = data[4];
                next.sprites_enable = data[5];
                next.layer2_enable  = data[6];
                next.bm_wrap        = data[7];
            end
            3'd3:    next.irqline = data[8:0];
            3'd4:    next.l1_scrx = data[8:0];
            3'd5:    next.l1_scry = data[7:0];
            3'd6:    next.l2_scrx = data[8:0];
            3'd7:    next.l2_scry = data[7:0];
            default: ;
        endcase
        return next;
    endfunction

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    ////////////////////////////////////////
    // Trace operations
    ////////////////////////////////////////
    task automatic run_line(input string line);
        byte         op;
        logic [31:0] f1, f2, f3, f4, f5, f6;
        logic [31:0] rd;
        int          count;
        string       name;
        op    = line.getc(0);
        count = 1;
        case (op)
            "W": begin
                void'($sscanf(line, "%c %h %h", op, f1, f2));
                bus_cycle(1'b1, f1, f2, rd);
                if ((f1 & ~32'h1f) == `AQ32_ADDR_VIDEO) begin
                    exp_cfg = video_after_write(exp_cfg, f1, f2);
                end
                if (video_cfg !== exp_cfg) begin
                    $display("ERROR at %0t: video_cfg %h, expected %h", $time,
                             video_cfg, exp_cfg);
                    note_error();
                end
            end
            "R": begin
                void'($sscanf(line, "%c %h %h %d", op, f1, f2, count));
                for (int i = 0; i < count; i++) begin
                    bus_cycle(1'b0, f1, 32'h0, rd);
                    if (rd !== f2 + 32'(i)) begin
                        $display("ERROR at %0t: read %h from %h, expected %h", $time,
                                 rd, f1, f2 + 32'(i));
                        note_error();
                    end
                end
            end
            "G": begin
                void'($sscanf(line, "%c %h %h", op, f1, f2));
                bus_cycle(1'b0, f1, 32'h0, rd);
                if (rd < f2) begin
                    $display("ERROR at %0t: read %h from %h, below %h", $time, rd, f1, f2);
                    note_error();
                end
            end
            "K": begin
                void'($sscanf(line, "%c %h %d", op, f1, count));
                for (int i = 0; i < count; i++) begin
                    @(negedge clk);
                    key_in = '{valid: 1'b1, data: f1[15:0] + 16'(i)};
                end
                @(negedge clk);
                key_in = '0;
            end
            "I": begin
                void'($sscanf(line, "%c %d %d", op, f1, f2));
                @(negedge clk);
                if (irq.timer !== f1[0] || irq.keybuf !== f2[0]) begin
                    $display("ERROR at %0t: irq timer %b keybuf %b, expected %b %b", $time,
                             irq.timer, irq.keybuf, f1[0], f2[0]);
                    note_error();
                end
            end
            "A": begin
                void'($sscanf(line, "%c %h %h %h %h %h %h", op, f1, f2, f3, f4, f5, f6));
                @(negedge clk);
                pcm_in = {f1[15:0], f2[15:0]};
                fm_in  = {f3[15:0], f4[15:0]};
                // Registered sum needs two cycles
                repeat (2) @(negedge clk);
                if (audio_out !== {f5[15:0], f6[15:0]}) begin
                    $display("ERROR at %0t: mix %h, expected %h%h", $time, audio_out,
                             f5[15:0], f6[15:0]);
                    note_error();
                end
            end
            "N": begin
                void'($sscanf(line, "%c %d", op, count));
                idle(count);
            end
            "E": begin
                void'($sscanf(line, "%c %s", op, name));
                finish_test(name);
            end
            default: begin
                $display("Unknown operation in trace line: %s", line);
                note_error();
            end
        endcase
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        int    fd;
        string line;
        reset        = 1'b1;
        wb_req       = '0;
        key_in       = '0;
        pcm_in       = '0;
        fm_in        = '0;
        exp_cfg      = '0;
        test_errors  = 0;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        void'($urandom(32'hbaee7ae2));
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the trace file %s", TRACE_FILE);
            $display("TEST FAIL");
            $finish;
        end else begin
            while ($fgets(line, fd) > 0) begin
                lines.push_back(line);
            end
            $fclose(fd);
            limit_cycles = lines.size() * LINE_CYCLES;
            repeat (2) @(posedge clk);
            @(negedge clk);
            reset = 1'b0;
            foreach (lines[i]) begin
                // Skip comments and blank lines
                if (lines[i].len() > 1 && lines[i].getc(0) != "#") begin
                    run_line(lines[i]);
                end
            end
            $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
            if (total_errors == 0 && tests_failed == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
            $finish;
        end
    end

    // Budget grows with the trace length
    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Run stopped by the watchdog after %0d cycles", limit_cycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: aq32_periph.f
+incdir+src
src/aq32_bus_pkg.sv
src/aq32_periph_pkg.sv
src/bus_decode.sv
src/mtime_timer.sv
src/key_buffer.sv
src/video_regs.sv
src/audio_mixer.sv
src/aq32_periph_top.sv
dv/tb_aq32_periph.sv

// File: run.sh
#!/bin/sh
# Builds the peripheral testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_aq32_periph -f aq32_periph.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_aq32_periph)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

// File: dv/aq32_periph_trace.txt
# W addr data | R addr expected [count] | G addr minimum | K keydata [count] | N cycles
# A pcm_l pcm_r fm_l fm_r exp_l exp_r | I irq_timer irq_keybuf | E name (hex except counts)
W 00002040 000001a5
R 00002040 000000a5
W 0000204c 0000ff37
R 0000204c 00000137
W 00002050 ffffffff
R 00002050 000001ff
W 00002054 00000abc
R 00002054 000000bc
W 00002058 00000321
R 00002058 00000121
W 0000205c 12345678
R 0000205c 00000078
R 00002044 00000000
E video_regs
W 00002084 12345678
R 00002084 12345678
W 00002088 00000003
W 0000208c 00000000
R 00002088 00000003
W 00002084 00000000
W 00002080 00000000
I 0 0
N 40
I 1 0
G 00002080 00000003
E timer_compare
K 0041 3
I 1 1
R 00002010 00000041 3
R 00002010 80000000
I 1 0
E keybuf_order
K 0055 1
I 1 1
W 00002010 00000000
I 1 0
K 0100 18
I 1 1
R 00002010 00000100 16
R 00002010 80000000
I 1 0
E keybuf_limits
A 1000 2000 0100 fe00 1100 1e00
A 7000 7fff 1000 0001 7fff 7fff
A 8000 9000 ffff 9000 8000 8000
A 7fff 8000 8000 7fff ffff ffff
E mixer
R 00002014 00000000
R 00003000 00000000
E unmapped
